// ==== hdl/operand_fetch_settings.svh ====
`ifndef OPERAND_FETCH_SETTINGS_SVH
`define OPERAND_FETCH_SETTINGS_SVH

// value width of channels, block registers and arguments
`define OF_DATA_WIDTH 16

// channel register file depth
`define OF_N_CHANNELS 16

// opaque operation code, carried untouched
`define OF_OP_WIDTH 5

// pending write counter, per channel and per substage
`define OF_PENDING_WIDTH 4

// operands a, b, c and one substage each
`define OF_N_OPERANDS 3

`endif

// ==== hdl/operand_fetch_pkg.sv ====
`default_nettype none

`include "operand_fetch_settings.svh"

package operand_fetch_pkg;

	typedef logic signed [`OF_DATA_WIDTH-1:0] data_t;

	// 4 bits for sixteen channels
	typedef logic [$clog2(`OF_N_CHANNELS)-1:0] chan_addr_t;

	typedef logic [`OF_OP_WIDTH-1:0] op_t;
	typedef logic [`OF_PENDING_WIDTH-1:0] pending_t;

	typedef enum logic [1:0] {
		idle,
		busy,
		done
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== hdl/channel_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "operand_fetch_settings.svh"

module channel_file
	import operand_fetch_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic write_enable,
	input chan_addr_t write_addr,
	input data_t write_val,

	input chan_addr_t read_addr,
	output data_t read_data
);

	data_t channels [`OF_N_CHANNELS];

	// shared by all three substages, one write port from writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `OF_N_CHANNELS; i++) begin
				channels[i] <= '0;
			end
		end else if (write_enable) begin
			channels[write_addr] <= write_val;
		end
	end

	// single read port, address comes from the arbiter
	assign read_data = channels[read_addr];

endmodule

`default_nettype wire

// ==== hdl/read_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "operand_fetch_settings.svh"

module read_arbiter
	import operand_fetch_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic [`OF_N_OPERANDS-1:0] req,
	input chan_addr_t addr_1, addr_2, addr_3,

	output logic [`OF_N_OPERANDS-1:0] grant,
	output chan_addr_t read_addr
);

	// later substage wins so the pipeline drains first
	always_comb begin
		grant = '0;
		read_addr = addr_1;
		if (req[2]) begin
			grant[2] = 1'b1;
			read_addr = addr_3;
		end else if (req[1]) begin
			grant[1] = 1'b1;
			read_addr = addr_2;
		end else if (req[0]) begin
			grant[0] = 1'b1;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

	a_grant_in_req: assert property (@(posedge clk) disable iff (reset) (grant & ~req) == '0);

endmodule

`default_nettype wire

// ==== hdl/pending_writes.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "operand_fetch_settings.svh"

module pending_writes
	import operand_fetch_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic issue,
	input chan_addr_t issue_addr,

	input logic write_enable,
	input chan_addr_t write_addr,

	input chan_addr_t query_addr,
	output pending_t pending
);

	pending_t counters [`OF_N_CHANNELS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `OF_N_CHANNELS; i++) begin
				counters[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `OF_N_CHANNELS; i++) begin
				case ({issue && issue_addr == chan_addr_t'(i),
						write_enable && write_addr == chan_addr_t'(i)})
					2'b10: counters[i] <= counters[i] + 1'b1;
					2'b01: begin
						if (counters[i] != '0) // saturate at zero
							counters[i] <= counters[i] - 1'b1;
					end
					default: counters[i] <= counters[i]; // none, or issue and land together
				endcase
			end
		end
	end

	assign pending = counters[query_addr];

	// more writes in flight to one channel than the counter can hold
	a_no_wrap: assert property (@(posedge clk) disable iff (reset)
		issue && !(write_enable && write_addr == issue_addr) |-> counters[issue_addr] != '1);

endmodule

`default_nettype wire

// ==== hdl/fetch_substage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_substage
	import operand_fetch_pkg::*;
#(
	parameter int operand_index = 0
)
(
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,

	input chan_addr_t src_a, src_b, src_c,
	input logic src_a_reg, src_b_reg, src_c_reg,
	input logic arg_a_needed, arg_b_needed, arg_c_needed,
	input data_t arg_a_in, arg_b_in, arg_c_in,
	input data_t register_0, register_1,
	input chan_addr_t dest,
	input logic writes_channel,
	input op_t op,

	output chan_addr_t src_a_out, src_b_out, src_c_out,
	output logic src_a_reg_out, src_b_reg_out, src_c_reg_out,
	output logic arg_a_needed_out, arg_b_needed_out, arg_c_needed_out,
	output data_t arg_a_out, arg_b_out, arg_c_out,
	output data_t register_0_out, register_1_out,
	output chan_addr_t dest_out,
	output logic writes_channel_out,
	output op_t op_out,

	output logic read_req,
	output chan_addr_t read_addr,
	input logic read_grant,
	input data_t read_data,

	input logic channel_write_enable,
	input chan_addr_t channel_write_addr,
	input data_t channel_write_val
);

	fetch_state_t state;
	chan_addr_t sel_src;
	logic sel_reg, sel_needed;
	logic forward, resolved, issue;
	pending_t pending;
	data_t arg_value;

	// the operand this substage owns, taken from the latched instruction
	always_comb begin
		case (operand_index)
			0: begin
				sel_src = src_a_out;
				sel_reg = src_a_reg_out;
				sel_needed = arg_a_needed_out;
			end
			1: begin
				sel_src = src_b_out;
				sel_reg = src_b_reg_out;
				sel_needed = arg_b_needed_out;
			end
			default: begin
				sel_src = src_c_out;
				sel_reg = src_c_reg_out;
				sel_needed = arg_c_needed_out;
			end
		endcase
	end

	pending_writes pending_writes (
		.clk, .reset,
		.issue, .issue_addr(dest_out),
		.write_enable(channel_write_enable), .write_addr(channel_write_addr),
		.query_addr(sel_src), .pending
	);

	always_comb begin
		if (!sel_needed)
			arg_value = '0;
		else if (sel_reg)
			arg_value = sel_src[0] ? register_1_out : register_0_out;
		else if (pending == '0)
			arg_value = read_data;
		else
			arg_value = channel_write_val; // last outstanding write lands now
	end

	assign read_req = (state == busy) && sel_needed && !sel_reg && pending == '0;
	assign read_addr = sel_src;
	assign forward = pending == pending_t'(1) && channel_write_enable
		&& channel_write_addr == sel_src;
	assign resolved = (state == busy)
		&& (!sel_needed || sel_reg || (read_req && read_grant) || forward);
	assign issue = resolved && writes_channel_out;

	assign in_ready = (state == idle);
	assign out_valid = (state == done);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: state <= in_valid ? busy : idle;
				busy: state <= resolved ? done : busy;
				default: state <= out_ready ? idle : done;
			endcase
		end
	end

	// latched fields double as outputs, held through done
	always_ff @(posedge clk) begin
		if (state == idle && in_valid) begin
			src_a_out <= src_a;
			src_b_out <= src_b;
			src_c_out <= src_c;
			src_a_reg_out <= src_a_reg;
			src_b_reg_out <= src_b_reg;
			src_c_reg_out <= src_c_reg;
			arg_a_needed_out <= arg_a_needed;
			arg_b_needed_out <= arg_b_needed;
			arg_c_needed_out <= arg_c_needed;
			arg_a_out <= arg_a_in;
			arg_b_out <= arg_b_in;
			arg_c_out <= arg_c_in;
			register_0_out <= register_0;
			register_1_out <= register_1;
			dest_out <= dest;
			writes_channel_out <= writes_channel;
			op_out <= op;
		end else if (resolved) begin
			case (operand_index)
				0: arg_a_out <= arg_value;
				1: arg_b_out <= arg_value;
				default: arg_c_out <= arg_value;
			endcase
		end
	end

	a_valid_held: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid);

endmodule

`default_nettype wire

// ==== hdl/operand_fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "operand_fetch_settings.svh"

module operand_fetch_stage
	import operand_fetch_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input chan_addr_t src_a, src_b, src_c,
	input logic src_a_reg, src_b_reg, src_c_reg,
	input logic arg_a_needed, arg_b_needed, arg_c_needed,
	input data_t register_0, register_1,
	input chan_addr_t dest,
	input logic writes_channel,
	input op_t op,

	input logic channel_write_enable,
	input chan_addr_t channel_write_addr,
	input data_t channel_write_val,

	output logic out_valid,
	input logic out_ready,
	output data_t arg_a_out, arg_b_out, arg_c_out,
	output chan_addr_t dest_out,
	output logic writes_channel_out,
	output op_t op_out
);

	logic valid_1, valid_2, ready_2, ready_3;
	chan_addr_t src_a_1, src_b_1, src_c_1, src_a_2, src_b_2, src_c_2;
	logic src_a_reg_1, src_b_reg_1, src_c_reg_1, src_a_reg_2, src_b_reg_2, src_c_reg_2;
	logic needed_a_1, needed_b_1, needed_c_1, needed_a_2, needed_b_2, needed_c_2;
	data_t arg_a_1, arg_b_1, arg_c_1, arg_a_2, arg_b_2, arg_c_2;
	data_t register_0_1, register_1_1, register_0_2, register_1_2;
	chan_addr_t dest_1, dest_2;
	logic writes_channel_1, writes_channel_2;
	op_t op_1, op_2;

	logic [`OF_N_OPERANDS-1:0] read_req, read_grant;
	chan_addr_t read_addr_1, read_addr_2, read_addr_3, read_addr;
	data_t read_data;

	fetch_substage #(.operand_index(0)) fetch_1 (
		.clk, .reset,
		.in_valid, .in_ready, .out_valid(valid_1), .out_ready(ready_2),
		.src_a, .src_b, .src_c, .src_a_reg, .src_b_reg, .src_c_reg,
		.arg_a_needed, .arg_b_needed, .arg_c_needed,
		.arg_a_in('0), .arg_b_in('0), .arg_c_in('0), // nothing resolved yet
		.register_0, .register_1, .dest, .writes_channel, .op,
		.src_a_out(src_a_1), .src_b_out(src_b_1), .src_c_out(src_c_1),
		.src_a_reg_out(src_a_reg_1), .src_b_reg_out(src_b_reg_1), .src_c_reg_out(src_c_reg_1),
		.arg_a_needed_out(needed_a_1), .arg_b_needed_out(needed_b_1),
		.arg_c_needed_out(needed_c_1),
		.arg_a_out(arg_a_1), .arg_b_out(arg_b_1), .arg_c_out(arg_c_1),
		.register_0_out(register_0_1), .register_1_out(register_1_1),
		.dest_out(dest_1), .writes_channel_out(writes_channel_1), .op_out(op_1),
		.read_req(read_req[0]), .read_addr(read_addr_1), .read_grant(read_grant[0]), .read_data,
		.channel_write_enable, .channel_write_addr, .channel_write_val
	);

	fetch_substage #(.operand_index(1)) fetch_2 (
		.clk, .reset,
		.in_valid(valid_1), .in_ready(ready_2), .out_valid(valid_2), .out_ready(ready_3),
		.src_a(src_a_1), .src_b(src_b_1), .src_c(src_c_1),
		.src_a_reg(src_a_reg_1), .src_b_reg(src_b_reg_1), .src_c_reg(src_c_reg_1),
		.arg_a_needed(needed_a_1), .arg_b_needed(needed_b_1), .arg_c_needed(needed_c_1),
		.arg_a_in(arg_a_1), .arg_b_in(arg_b_1), .arg_c_in(arg_c_1),
		.register_0(register_0_1), .register_1(register_1_1),
		.dest(dest_1), .writes_channel(writes_channel_1), .op(op_1),
		.src_a_out(src_a_2), .src_b_out(src_b_2), .src_c_out(src_c_2),
		.src_a_reg_out(src_a_reg_2), .src_b_reg_out(src_b_reg_2), .src_c_reg_out(src_c_reg_2),
		.arg_a_needed_out(needed_a_2), .arg_b_needed_out(needed_b_2),
		.arg_c_needed_out(needed_c_2),
		.arg_a_out(arg_a_2), .arg_b_out(arg_b_2), .arg_c_out(arg_c_2),
		.register_0_out(register_0_2), .register_1_out(register_1_2),
		.dest_out(dest_2), .writes_channel_out(writes_channel_2), .op_out(op_2),
		.read_req(read_req[1]), .read_addr(read_addr_2), .read_grant(read_grant[1]), .read_data,
		.channel_write_enable, .channel_write_addr, .channel_write_val
	);

	// last substage, source fields are not needed downstream
	fetch_substage #(.operand_index(2)) fetch_3 (
		.clk, .reset,
		.in_valid(valid_2), .in_ready(ready_3), .out_valid, .out_ready,
		.src_a(src_a_2), .src_b(src_b_2), .src_c(src_c_2),
		.src_a_reg(src_a_reg_2), .src_b_reg(src_b_reg_2), .src_c_reg(src_c_reg_2),
		.arg_a_needed(needed_a_2), .arg_b_needed(needed_b_2), .arg_c_needed(needed_c_2),
		.arg_a_in(arg_a_2), .arg_b_in(arg_b_2), .arg_c_in(arg_c_2),
		.register_0(register_0_2), .register_1(register_1_2),
		.dest(dest_2), .writes_channel(writes_channel_2), .op(op_2),
		.src_a_out(), .src_b_out(), .src_c_out(),
		.src_a_reg_out(), .src_b_reg_out(), .src_c_reg_out(),
		.arg_a_needed_out(), .arg_b_needed_out(), .arg_c_needed_out(),
		.arg_a_out, .arg_b_out, .arg_c_out,
		.register_0_out(), .register_1_out(),
		.dest_out, .writes_channel_out, .op_out,
		.read_req(read_req[2]), .read_addr(read_addr_3), .read_grant(read_grant[2]), .read_data,
		.channel_write_enable, .channel_write_addr, .channel_write_val
	);

	read_arbiter read_arbiter (
		.clk, .reset,
		.req(read_req), .addr_1(read_addr_1), .addr_2(read_addr_2), .addr_3(read_addr_3),
		.grant(read_grant), .read_addr
	);

	channel_file channel_file (
		.clk, .reset,
		.write_enable(channel_write_enable), .write_addr(channel_write_addr),
		.write_val(channel_write_val),
		.read_addr, .read_data
	);

endmodule

`default_nettype wire

// ==== tb/tb_operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_operand_fetch
	import operand_fetch_pkg::*;
;

	localparam int n_instr = 400;
	localparam int watchdog_cycles = n_instr * 40 + 16;

	logic clk, reset;
	logic in_valid, in_ready, out_valid, out_ready;
	chan_addr_t src_a, src_b, src_c, dest, dest_out;
	logic src_a_reg, src_b_reg, src_c_reg;
	logic arg_a_needed, arg_b_needed, arg_c_needed;
	data_t register_0, register_1;
	logic writes_channel, writes_channel_out;
	op_t op, op_out;
	logic channel_write_enable;
	chan_addr_t channel_write_addr;
	data_t channel_write_val;
	data_t arg_a_out, arg_b_out, arg_c_out;

	integer seed;
	data_t shadow [16]; // channel contents as the model sees them
	data_t exp_a_q[$], exp_b_q[$], exp_c_q[$];
	chan_addr_t exp_dest_q[$];
	logic exp_wr_q[$];
	op_t exp_op_q[$];
	chan_addr_t wb_dest_q[$];
	data_t wb_val_q[$];
	int wb_seq_q[$];
	data_t next_wb_val;
	int presented, accepted, departed, wb_delay;
	logic fast;

	operand_fetch_stage DUT (.*);

	always #4 clk = ~clk;

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic data_t model_operand(input logic needed, input logic is_reg,
			input chan_addr_t src);
		if (!needed)
			return '0;
		if (is_reg)
			return src[0] ? register_1 : register_0;
		return shadow[src];
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display(">>> FAIL");
			$fatal(1, "value mismatch on %s", what);
		end
	endtask

	// writes land in issue order and only once the producer has left the stage
	task automatic drive_writeback();
		channel_write_enable = 1'b0;
		if (wb_dest_q.size() > 0 && wb_seq_q[0] < departed) begin
			if (wb_delay < 0)
				wb_delay = fast ? 0 : rand_below(5);
			if (wb_delay == 0) begin
				channel_write_enable = 1'b1;
				channel_write_addr = wb_dest_q.pop_front();
				channel_write_val = wb_val_q.pop_front();
				void'(wb_seq_q.pop_front());
				wb_delay = -1;
			end else begin
				wb_delay--;
			end
		end
	endtask

	task automatic drive_inputs(input logic was_accepted);
		out_ready = fast ? 1'b1 : (rand_below(4) != 0);
		if (in_valid && !was_accepted)
			return; // hold until taken
		in_valid = 1'b0;
		if (presented < n_instr && (fast || rand_below(3) != 0)) begin
			in_valid = 1'b1;
			src_a = chan_addr_t'(rand_below(4)); // small range gives lots of hazards
			src_b = chan_addr_t'(rand_below(4));
			src_c = chan_addr_t'(rand_below(4));
			src_a_reg = (rand_below(4) == 0);
			src_b_reg = (rand_below(4) == 0);
			src_c_reg = (rand_below(4) == 0);
			arg_a_needed = (rand_below(5) != 0);
			arg_b_needed = (rand_below(5) != 0);
			arg_c_needed = (rand_below(5) != 0);
			register_0 = data_t'($random(seed));
			register_1 = data_t'($random(seed));
			dest = chan_addr_t'(rand_below(4));
			writes_channel = (rand_below(3) != 0);
			op = op_t'($random(seed));
			next_wb_val = data_t'($random(seed));
			presented++;
		end
	endtask

	// values here are what the next rising edge sees
	task automatic observe(output logic took);
		if (out_valid) begin
			if (exp_a_q.size() == 0) begin
				$display(">>> FAIL");
				$fatal(1, "output valid while no instruction is outstanding");
			end
			check_value("arg_a_out", arg_a_out, exp_a_q[0]);
			check_value("arg_b_out", arg_b_out, exp_b_q[0]);
			check_value("arg_c_out", arg_c_out, exp_c_q[0]);
			check_value("dest_out", dest_out, exp_dest_q[0]);
			check_value("writes_channel_out", writes_channel_out, exp_wr_q[0]);
			check_value("op_out", op_out, exp_op_q[0]);
			if (out_ready) begin
				void'(exp_a_q.pop_front());
				void'(exp_b_q.pop_front());
				void'(exp_c_q.pop_front());
				void'(exp_dest_q.pop_front());
				void'(exp_wr_q.pop_front());
				void'(exp_op_q.pop_front());
				departed++;
			end
		end
		took = in_valid && in_ready;
		if (took) begin
			exp_a_q.push_back(model_operand(arg_a_needed, src_a_reg, src_a));
			exp_b_q.push_back(model_operand(arg_b_needed, src_b_reg, src_b));
			exp_c_q.push_back(model_operand(arg_c_needed, src_c_reg, src_c));
			exp_dest_q.push_back(dest);
			exp_wr_q.push_back(writes_channel);
			exp_op_q.push_back(op);
			if (writes_channel) begin
				shadow[dest] = next_wb_val; // younger readers see this value
				wb_dest_q.push_back(dest);
				wb_val_q.push_back(next_wb_val);
				wb_seq_q.push_back(accepted);
			end
			accepted++;
		end
	endtask

	initial begin
		logic took;
		seed = 32'hdd96_9e8d;
		clk = 1'b0;
		reset = 1'b1;
		{in_valid, out_ready, src_a, src_b, src_c, src_a_reg, src_b_reg, src_c_reg} = '0;
		{arg_a_needed, arg_b_needed, arg_c_needed, register_0, register_1} = '0;
		{dest, writes_channel, op, next_wb_val} = '0;
		{channel_write_enable, channel_write_addr, channel_write_val} = '0;
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		presented = 0;
		accepted = 0;
		departed = 0;
		wb_delay = -1;
		fast = 1'b0;
		took = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("in_ready after reset", in_ready, 1);
		check_value("out_valid after reset", out_valid, 0);

		while (departed < n_instr || wb_dest_q.size() > 0) begin
			fast = (accepted >= n_instr / 2); // second half runs without stalls or writeback delay
			drive_writeback();
			drive_inputs(took);
			observe(took);
			@(negedge clk);
		end
		channel_write_enable = 1'b0;
		in_valid = 1'b0;
		repeat (4) begin
			observe(took); // anything leaving now was never accepted
			@(negedge clk);
		end

		check_value("out_valid at end", out_valid, 0);
		$display(">>> PASS");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display(">>> FAIL");
		$fatal(1, "timeout, the pipeline stopped delivering instructions");
	end

endmodule

`default_nettype wire

// ==== operand_fetch_stage.f ====
+incdir+hdl
hdl/operand_fetch_pkg.sv
hdl/channel_file.sv
hdl/read_arbiter.sv
hdl/pending_writes.sv
hdl/fetch_substage.sv
hdl/operand_fetch_stage.sv
tb/tb_operand_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the operand fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_operand_fetch \
	-f operand_fetch_stage.f \
	--Mdir obj_dir \
	-o tb_operand_fetch

./obj_dir/tb_operand_fetch
